// File: wb_flash_ctrl.f
logic/flash_pkg.sv
logic/flash_addr_regs.sv
logic/flash_wait_timer.sv
logic/flash_access_fsm.sv
logic/flash_read_latch.sv
logic/wb_flash_ctrl.sv
verification/flash_model.sv
verification/wb_flash_ctrl_assertions.sv
verification/tb_wb_flash_ctrl.sv

// File: Makefile
TOP = tb_wb_flash_ctrl
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f wb_flash_ctrl.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^>>> PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: verification/tb_wb_flash_ctrl.sv
// Testbench for the Wishbone NOR flash read controller
// Applies a table of register and data window accesses and checks data and latency
`default_nettype none

module tb_wb_flash_ctrl;

  localparam int RESET_CYCLES = 8;
  localparam int HALF_PERIOD  = 20;               // 40 unit clock
  localparam int MAX_ENTRIES  = 40;
  localparam bit OP_WR        = 1'b1;
  localparam bit OP_RD        = 1'b0;

  logic                   wb_clk_i;
  logic                   wb_rst_i;
  flash_pkg::wb_data_t    wb_dat_i;
  wire flash_pkg::wb_data_t wb_dat_o;
  logic                   wb_we_i;
  flash_pkg::reg_sel_t    wb_adr_i;
  logic [1:0]             wb_sel_i;
  logic                   wb_stb_i;
  logic                   wb_cyc_i;
  wire                    wb_ack_o;
  wire flash_pkg::flash_addr_t flash_addr;
  wire flash_pkg::wb_data_t    flash_data;
  wire                    flash_we_n;
  wire                    flash_oe_n;
  wire                    flash_ce_n;
  wire                    flash_rst_n;

  // ------------------------------
  // Stimulus table
  // ------------------------------
  bit                  tbl_op    [MAX_ENTRIES];   // Write or read
  flash_pkg::reg_sel_t tbl_sel   [MAX_ENTRIES];   // Register offset
  flash_pkg::wb_data_t tbl_wdata [MAX_ENTRIES];   // Write data
  flash_pkg::wb_data_t tbl_exp   [MAX_ENTRIES];   // Expected read data
  int                  tbl_len = 0;

  int unsigned cycle_count = 0;                   // Clocks since start
  int unsigned cycle_limit = 0;                   // Set once the table exists

  wb_flash_ctrl wb_flash_ctrl_inst (
    .wb_clk_i      (wb_clk_i),
    .wb_rst_i      (wb_rst_i),
    .wb_dat_i      (wb_dat_i),
    .wb_dat_o      (wb_dat_o),
    .wb_we_i       (wb_we_i),
    .wb_adr_i      (wb_adr_i),
    .wb_sel_i      (wb_sel_i),
    .wb_stb_i      (wb_stb_i),
    .wb_cyc_i      (wb_cyc_i),
    .wb_ack_o      (wb_ack_o),
    .flash_addr_o  (flash_addr),
    .flash_data_i  (flash_data),
    .flash_we_n_o  (flash_we_n),
    .flash_oe_n_o  (flash_oe_n),
    .flash_ce_n_o  (flash_ce_n),
    .flash_rst_n_o (flash_rst_n)
  );

  flash_model u_flash (
    .clk_i  (wb_clk_i),
    .rst_i  (wb_rst_i),
    .addr_i (flash_addr),
    .ce_n_i (flash_ce_n),
    .oe_n_i (flash_oe_n),
    .data_o (flash_data)
  );

  bind wb_flash_ctrl wb_flash_ctrl_assertions u_checks (
    .wb_clk_i     (wb_clk_i),
    .wb_rst_i     (wb_rst_i),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_ack_o     (wb_ack_o),
    .flash_we_n_o (flash_we_n_o),
    .flash_ce_n_o (flash_ce_n_o),
    .flash_oe_n_o (flash_oe_n_o),
    .state_i      (u_fsm.state_q)
  );

  initial begin
    wb_clk_i = 1'b0;
    forever #HALF_PERIOD wb_clk_i = ~wb_clk_i;
  end

  // Run limit from the table length
  always @(posedge wb_clk_i) begin
    cycle_count++;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      $display("Timeout: the bus accesses did not finish within %0d clock cycles",
               cycle_limit);
      $display(">>> FAIL");
      $fatal(1, "Run stopped by timeout");
    end
  end

  // Flash word for an address: low half XOR upper six bits moved to 15..10
  function automatic flash_pkg::wb_data_t flash_pattern(input flash_pkg::flash_addr_t addr);
    flash_pkg::wb_data_t upper;
    upper = {10'b0, addr[21:16]};
    return addr[15:0] ^ (upper << 10);
  endfunction

  task automatic add_entry(input bit op, input flash_pkg::reg_sel_t sel,
                           input flash_pkg::wb_data_t wdata, input flash_pkg::wb_data_t exp);
    tbl_op[tbl_len]    = op;
    tbl_sel[tbl_len]   = sel;
    tbl_wdata[tbl_len] = wdata;
    tbl_exp[tbl_len]   = exp;
    tbl_len++;
  endtask

  task automatic build_table;
    flash_pkg::wb_data_t    lo;
    flash_pkg::wb_data_t    hi;
    flash_pkg::flash_addr_t a;
    lo = flash_pkg::wb_data_t'($urandom);
    hi = flash_pkg::wb_data_t'($urandom);
    a  = {hi[5:0], lo};
    // Reset values
    add_entry(OP_RD, flash_pkg::REG_ALO, 16'h0, 16'h0);
    add_entry(OP_RD, flash_pkg::REG_AHI, 16'h0, 16'h0);
    add_entry(OP_RD, flash_pkg::REG_CTRL, 16'h0, 16'h0);
    add_entry(OP_RD, flash_pkg::REG_DATA, 16'h0, flash_pattern('0));
    // Address readback, then a data read and repeats without increment
    add_entry(OP_WR, flash_pkg::REG_ALO, lo, 16'h0);
    add_entry(OP_RD, flash_pkg::REG_ALO, 16'h0, lo);
    add_entry(OP_WR, flash_pkg::REG_AHI, hi, 16'h0);
    add_entry(OP_RD, flash_pkg::REG_AHI, 16'h0, {10'b0, hi[5:0]});
    add_entry(OP_RD, flash_pkg::REG_DATA, 16'h0, flash_pattern(a));
    add_entry(OP_RD, flash_pkg::REG_DATA, 16'h0, flash_pattern(a));
    add_entry(OP_RD, flash_pkg::REG_ALO, 16'h0, lo);
    add_entry(OP_RD, flash_pkg::REG_AHI, 16'h0, {10'b0, hi[5:0]});
    // Data window write is ignored
    add_entry(OP_WR, flash_pkg::REG_DATA, flash_pkg::wb_data_t'($urandom), 16'h0);
    add_entry(OP_RD, flash_pkg::REG_ALO, 16'h0, lo);
    add_entry(OP_RD, flash_pkg::REG_AHI, 16'h0, {10'b0, hi[5:0]});
    add_entry(OP_RD, flash_pkg::REG_DATA, 16'h0, flash_pattern(a));
    // Auto-increment walk from a new random address
    lo = flash_pkg::wb_data_t'($urandom);
    hi = flash_pkg::wb_data_t'($urandom);
    a  = {hi[5:0], lo};
    add_entry(OP_WR, flash_pkg::REG_CTRL, 16'h1, 16'h0);
    add_entry(OP_RD, flash_pkg::REG_CTRL, 16'h0, 16'h1);
    add_entry(OP_WR, flash_pkg::REG_ALO, lo, 16'h0);
    add_entry(OP_WR, flash_pkg::REG_AHI, hi, 16'h0);
    add_entry(OP_RD, flash_pkg::REG_DATA, 16'h0, flash_pattern(a));
    add_entry(OP_RD, flash_pkg::REG_DATA, 16'h0, flash_pattern(a + 22'd1));
    add_entry(OP_RD, flash_pkg::REG_DATA, 16'h0, flash_pattern(a + 22'd2));
    a = a + 22'd3;
    add_entry(OP_RD, flash_pkg::REG_ALO, 16'h0, a[15:0]);
    add_entry(OP_RD, flash_pkg::REG_AHI, 16'h0, {10'b0, a[21:16]});
    // Wrap at the top of the address space
    add_entry(OP_WR, flash_pkg::REG_ALO, 16'hFFFF, 16'h0);
    add_entry(OP_WR, flash_pkg::REG_AHI, 16'h003F, 16'h0);
    add_entry(OP_RD, flash_pkg::REG_DATA, 16'h0, flash_pattern(22'h3FFFFF));
    add_entry(OP_RD, flash_pkg::REG_ALO, 16'h0, 16'h0);
    add_entry(OP_RD, flash_pkg::REG_AHI, 16'h0, 16'h0);
    add_entry(OP_RD, flash_pkg::REG_DATA, 16'h0, flash_pattern('0));
  endtask

  // ------------------------------
  // Bus cycles, entered on a falling edge
  // ------------------------------
  task automatic wb_write(input flash_pkg::reg_sel_t sel, input flash_pkg::wb_data_t data,
                          output int cycles);
    wb_adr_i = sel;
    wb_dat_i = data;
    wb_we_i  = 1'b1;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    cycles   = 0;
    do begin
      @(negedge wb_clk_i);
      cycles++;
    end while (!wb_ack_o);
    @(negedge wb_clk_i);                          // Request held over the ack edge
    wb_stb_i = 1'b0;                              // Release after the acknowledge
    wb_cyc_i = 1'b0;
    wb_we_i  = 1'b0;
    @(negedge wb_clk_i);
  endtask

  task automatic wb_read(input flash_pkg::reg_sel_t sel, output flash_pkg::wb_data_t data,
                         output int cycles);
    wb_adr_i = sel;
    wb_we_i  = 1'b0;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    cycles   = 0;
    do begin
      @(negedge wb_clk_i);
      cycles++;
    end while (!wb_ack_o);
    data     = wb_dat_o;                          // Stable mid-cycle
    @(negedge wb_clk_i);                          // Request held over the ack edge
    wb_stb_i = 1'b0;
    wb_cyc_i = 1'b0;
    @(negedge wb_clk_i);
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("Mismatch at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
      $display(">>> FAIL");
      $fatal(1, "Check failed");
    end
  endtask

  initial begin
    flash_pkg::wb_data_t rd_data;
    int                  cycles;
    int                  exp_cycles;
    wb_rst_i = 1'b1;
    wb_dat_i = '0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_sel_i = 2'b11;                             // Always full word
    wb_stb_i = 1'b0;
    wb_cyc_i = 1'b0;
    void'($urandom(86));
    build_table();
    cycle_limit = tbl_len * (flash_pkg::ACCESS_WAIT + 4) + RESET_CYCLES;
    repeat (RESET_CYCLES) @(negedge wb_clk_i);
    wb_rst_i = 1'b0;
    @(negedge wb_clk_i);

    // Pads after reset
    check_value(32'(flash_rst_n), 32'(1'b1), "flash reset pad after reset");
    check_value(32'(flash_we_n), 32'(1'b1), "flash write enable after reset");
    check_value(32'(flash_ce_n), 32'(1'b1), "flash chip enable after reset");
    check_value(32'(flash_oe_n), 32'(1'b1), "flash output enable after reset");
    check_value(32'(flash_addr), 32'h0, "flash address after reset");

    for (int i = 0; i < tbl_len; i++) begin
      if (tbl_op[i] == OP_WR) begin
        wb_write(tbl_sel[i], tbl_wdata[i], cycles);
        exp_cycles = 1;
      end else begin
        wb_read(tbl_sel[i], rd_data, cycles);
        check_value(32'(rd_data), 32'(tbl_exp[i]), $sformatf("read data of entry %0d", i));
        exp_cycles = (tbl_sel[i] == flash_pkg::REG_DATA) ? flash_pkg::ACCESS_WAIT + 1 : 1;
      end
      check_value(32'(cycles), 32'(exp_cycles), $sformatf("ack latency of entry %0d", i));
    end

    if (wb_flash_ctrl_inst.u_checks.fail_count != 0) begin
      $display("Bound assertions failed %0d times", wb_flash_ctrl_inst.u_checks.fail_count);
      $display(">>> FAIL");
      $fatal(1, "Assertion failures");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: verification/wb_flash_ctrl_assertions.sv
// Concurrent checks on the Wishbone handshake and flash strobes
// Bound into the controller top level
`default_nettype none

module wb_flash_ctrl_assertions (
  input wire                          wb_clk_i,
  input wire                          wb_rst_i,
  input wire                          wb_cyc_i,
  input wire                          wb_stb_i,
  input wire                          wb_ack_o,
  input wire                          flash_we_n_o,
  input wire                          flash_ce_n_o,
  input wire                          flash_oe_n_o,
  input wire flash_pkg::flash_state_t state_i     // Sequencer state
);

  int unsigned fail_count = 0;                    // Failed assertions so far

  // ------------------------------
  // Handshake
  // ------------------------------
  ack_single: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_ack_o |=> !wb_ack_o)
    else begin
      fail_count++;
      $error("Acknowledge held for more than one cycle");
    end

  ack_with_req: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_ack_o |-> (wb_cyc_i && wb_stb_i))
    else begin
      fail_count++;
      $error("Acknowledge without a request");
    end

  // ------------------------------
  // Flash strobes
  // ------------------------------
  we_inactive: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    flash_we_n_o)
    else begin
      fail_count++;
      $error("Flash write enable went low");
    end

  ce_matches_oe: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    flash_ce_n_o == flash_oe_n_o)
    else begin
      fail_count++;
      $error("Chip enable and output enable differ");
    end

  strobes_idle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (state_i != flash_pkg::READ_WAIT) |-> (flash_ce_n_o && flash_oe_n_o))
    else begin
      fail_count++;
      $error("Flash strobes active outside the read wait state");
    end

  // Chip enable low for exactly the access time
  strobe_length: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    $rose(flash_ce_n_o) |->
      (!$past(flash_ce_n_o, flash_pkg::ACCESS_WAIT) &&
       $past(flash_ce_n_o, flash_pkg::ACCESS_WAIT + 1)))
    else begin
      fail_count++;
      $error("Flash strobes not held low for the access time");
    end

endmodule

`default_nettype wire

// File: verification/flash_model.sv
// Behavioral NOR flash for the controller testbench
// Data is a function of the address, valid only after the access time
`default_nettype none

module flash_model (
  input  wire                          clk_i,
  input  wire                          rst_i,
  input  wire flash_pkg::flash_addr_t  addr_i,     // Word address pads
  input  wire                          ce_n_i,     // Chip enable, low active
  input  wire                          oe_n_i,     // Output enable, low active
  output wire flash_pkg::wb_data_t     data_o      // Data pads
);

  flash_pkg::wait_cnt_t low_cnt;                   // Cycles with both strobes low

  // Counted on the falling edge, half a cycle after the strobes change
  always @(negedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      low_cnt <= '0;
    end else if (!ce_n_i && !oe_n_i) begin
      if (low_cnt < flash_pkg::ACCESS_WAIT) begin
        low_cnt <= low_cnt + flash_pkg::wait_cnt_t'(1);   // Saturate at access time
      end
    end else begin
      low_cnt <= '0;                               // Strobes released
    end
  end

  // Pattern once the access time has passed, filler before
  assign data_o = (low_cnt >= flash_pkg::ACCESS_WAIT) ?
                  (addr_i[15:0] ^ {addr_i[21:16], 10'b0}) : 16'hDEAD;

endmodule

`default_nettype wire

// File: logic/wb_flash_ctrl.sv
// Wishbone classic slave for reading a 16-bit parallel NOR flash
// Connects the bus and the flash pads to the register, timer, FSM and latch blocks
`default_nettype none

module wb_flash_ctrl (
  // Wishbone slave
  input  wire                          wb_clk_i,
  input  wire                          wb_rst_i,
  input  wire flash_pkg::wb_data_t     wb_dat_i,
  output wire flash_pkg::wb_data_t     wb_dat_o,
  input  wire                          wb_we_i,
  input  wire flash_pkg::reg_sel_t     wb_adr_i,      // Word offset
  input  wire [1:0]                    wb_sel_i,      // Full-word accesses only
  input  wire                          wb_stb_i,
  input  wire                          wb_cyc_i,
  output wire                          wb_ack_o,
  // Flash pads
  output wire flash_pkg::flash_addr_t  flash_addr_o,
  input  wire flash_pkg::wb_data_t     flash_data_i,
  output wire                          flash_we_n_o,
  output wire                          flash_oe_n_o,
  output wire                          flash_ce_n_o,
  output wire                          flash_rst_n_o
);

  // ------------------------------
  // Internal connections
  // ------------------------------
  wire                        reg_wr;          // FSM to regs
  wire                        timer_start;     // FSM to timer
  wire flash_pkg::wait_cnt_t  timer_load;      // Access time count
  wire                        timer_done;      // Timer to FSM
  wire                        capture;         // Latch strobe and increment
  wire                        flash_access;    // Strobes active
  wire                        auto_inc;        // CTRL bit to readback

  flash_addr_regs u_regs (
    .wb_clk_i     (wb_clk_i),
    .wb_rst_i     (wb_rst_i),
    .reg_wr_i     (reg_wr),
    .reg_sel_i    (wb_adr_i),
    .wr_data_i    (wb_dat_i),
    .inc_i        (capture),                   // Step after each flash read
    .flash_addr_o (flash_addr_o),
    .auto_inc_o   (auto_inc)
  );

  flash_wait_timer u_timer (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .start_i  (timer_start),
    .load_i   (timer_load),
    .done_o   (timer_done)
  );

  flash_access_fsm u_fsm (
    .wb_clk_i       (wb_clk_i),
    .wb_rst_i       (wb_rst_i),
    .cyc_i          (wb_cyc_i),
    .stb_i          (wb_stb_i),
    .we_i           (wb_we_i),
    .sel_reg_i      (wb_adr_i),
    .timer_done_i   (timer_done),
    .reg_wr_o       (reg_wr),
    .start_o        (timer_start),
    .load_o         (timer_load),
    .capture_o      (capture),
    .flash_access_o (flash_access),
    .wb_ack_o       (wb_ack_o)
  );

  flash_read_latch u_latch (
    .wb_clk_i     (wb_clk_i),
    .wb_rst_i     (wb_rst_i),
    .capture_i    (capture),
    .flash_data_i (flash_data_i),
    .reg_sel_i    (wb_adr_i),
    .flash_addr_i (flash_addr_o),
    .auto_inc_i   (auto_inc),
    .wb_dat_o     (wb_dat_o)
  );

  // Pad strobes, read-only part
  assign flash_we_n_o  = 1'b1;                 // Never programs
  assign flash_rst_n_o = 1'b1;                 // Flash reset held inactive
  assign flash_ce_n_o  = ~flash_access;        // Chip enable tracks READ_WAIT
  assign flash_oe_n_o  = ~flash_access;        // Output enable same as CE

endmodule

`default_nettype wire

// File: logic/flash_read_latch.sv
// Flash read data latch and Wishbone read mux
// Holds the last flash word and selects register readback by offset
`default_nettype none

module flash_read_latch (
  input  wire                          wb_clk_i,
  input  wire                          wb_rst_i,
  input  wire                          capture_i,    // Capture strobe from FSM
  input  wire flash_pkg::wb_data_t     flash_data_i, // Flash data pads
  input  wire flash_pkg::reg_sel_t     reg_sel_i,    // Register offset
  input  wire flash_pkg::flash_addr_t  flash_addr_i, // Current address
  input  wire                          auto_inc_i,   // CTRL bit 0
  output logic [flash_pkg::DATA_W-1:0] wb_dat_o
);

  flash_pkg::wb_data_t data_q;                       // Last flash word

  // ------------------------------
  // Data capture
  // ------------------------------
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      data_q <= '0;                                  // Reads 0 before first access
    end else if (capture_i) begin
      data_q <= flash_data_i;
    end
  end

  // Readback mux, combinational so register reads need no extra cycle
  always_comb begin
    case (reg_sel_i)
      flash_pkg::REG_DATA: wb_dat_o = data_q;
      flash_pkg::REG_ALO:  wb_dat_o = flash_addr_i[flash_pkg::DATA_W-1:0];
      flash_pkg::REG_AHI: begin
        wb_dat_o = {{(flash_pkg::DATA_W - flash_pkg::AHI_W){1'b0}},
                    flash_addr_i[flash_pkg::ADDR_W-1:flash_pkg::DATA_W]}; // Upper bits zero
      end
      flash_pkg::REG_CTRL: wb_dat_o = {{(flash_pkg::DATA_W - 1){1'b0}}, auto_inc_i};
      default:             wb_dat_o = data_q;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/flash_access_fsm.sv
// Wishbone bus cycle sequencer
// Splits requests into register accesses and timed flash reads
`default_nettype none

module flash_access_fsm (
  input  wire                        wb_clk_i,
  input  wire                        wb_rst_i,
  input  wire                        cyc_i,          // Wishbone cycle
  input  wire                        stb_i,          // Wishbone strobe
  input  wire                        we_i,           // Write request
  input  wire flash_pkg::reg_sel_t   sel_reg_i,      // Register offset
  input  wire                        timer_done_i,   // Access time elapsed
  output logic                       reg_wr_o,       // Register write strobe
  output logic                       start_o,        // Timer load
  output logic [flash_pkg::WAIT_W-1:0] load_o,       // Timer load value
  output logic                       capture_o,      // Latch data, bump address
  output logic                       flash_access_o, // Flash strobes active
  output logic                       wb_ack_o
);

  flash_pkg::flash_state_t state_q;                  // Current state
  flash_pkg::flash_state_t state_d;                  // Next state
  logic                    req;                      // Valid bus request
  logic                    rd_flash;                 // Request targets the flash
  logic                    ack_q;                    // Registered acknowledge

  assign req      = cyc_i & stb_i;
  assign rd_flash = !we_i && (sel_reg_i == flash_pkg::REG_DATA);

  // ------------------------------
  // Next state and strobes
  // ------------------------------
  always_comb begin
    state_d   = state_q;
    reg_wr_o  = 1'b0;
    start_o   = 1'b0;
    capture_o = 1'b0;
    case (state_q)
      flash_pkg::IDLE: begin
        if (req) begin
          if (rd_flash) begin
            start_o = 1'b1;                          // Begin access time count
            state_d = flash_pkg::READ_WAIT;
          end else begin
            reg_wr_o = we_i;                         // Writes, data window too
            state_d  = flash_pkg::ACK;               // Register access, 1 cycle
          end
        end
      end
      flash_pkg::READ_WAIT: begin
        if (timer_done_i) begin
          capture_o = 1'b1;                          // Flash data valid now
          state_d   = flash_pkg::ACK;
        end
      end
      flash_pkg::ACK: begin
        state_d = flash_pkg::IDLE;                   // Never re-accept here
      end
      default: begin
        state_d = flash_pkg::IDLE;
      end
    endcase
  end

  // ------------------------------
  // State and acknowledge registers
  // ------------------------------
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      state_q <= flash_pkg::IDLE;
      ack_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      ack_q   <= (state_d == flash_pkg::ACK);        // High for the ACK cycle
    end
  end

  assign load_o         = flash_pkg::ACCESS_WAIT;          // Fixed access time
  assign flash_access_o = (state_q == flash_pkg::READ_WAIT); // CE and OE low
  assign wb_ack_o       = ack_q;

endmodule

`default_nettype wire

// File: logic/flash_wait_timer.sv
// Flash access time counter
// Loaded on start, flags done for one cycle as it reaches one
`default_nettype none

module flash_wait_timer (
  input  wire                        wb_clk_i,
  input  wire                        wb_rst_i,
  input  wire                        start_i,    // Load strobe from FSM
  input  wire flash_pkg::wait_cnt_t  load_i,     // Cycles to count
  output logic                       done_o      // Access time elapsed
);

  flash_pkg::wait_cnt_t cnt_q;                   // Remaining cycles

  // ------------------------------
  // Down-counter
  // ------------------------------
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      cnt_q <= '0;                               // Idle
    end else if (start_i) begin
      cnt_q <= load_i;                           // New access
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;                     // Count down, park at zero
    end
  end

  // Single-cycle pulse while the count sits at one
  assign done_o = (cnt_q == flash_pkg::wait_cnt_t'(1));

endmodule

`default_nettype wire

// File: logic/flash_addr_regs.sv
// Flash address and control registers
// Write decode from the Wishbone side plus auto-increment after reads
`default_nettype none

module flash_addr_regs (
  input  wire                       wb_clk_i,
  input  wire                       wb_rst_i,
  input  wire                       reg_wr_i,     // One-cycle write strobe
  input  wire flash_pkg::reg_sel_t  reg_sel_i,    // Register offset
  input  wire flash_pkg::wb_data_t  wr_data_i,    // Write data from bus
  input  wire                       inc_i,        // Flash word captured
  output logic [flash_pkg::ADDR_W-1:0] flash_addr_o,
  output logic                      auto_inc_o
);

  flash_pkg::flash_addr_t addr_q;                 // Current flash word address
  logic                   auto_inc_q;             // CTRL bit 0

  // ------------------------------
  // Register update
  // ------------------------------
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      addr_q     <= '0;                           // Start at word 0
      auto_inc_q <= 1'b0;                         // Auto-increment off
    end else if (reg_wr_i) begin
      case (reg_sel_i)
        flash_pkg::REG_ALO: begin
          addr_q[flash_pkg::DATA_W-1:0] <= wr_data_i;               // Low half
        end
        flash_pkg::REG_AHI: begin
          addr_q[flash_pkg::ADDR_W-1:flash_pkg::DATA_W] <=
            wr_data_i[flash_pkg::AHI_W-1:0];                        // Upper 6 bits only
        end
        flash_pkg::REG_CTRL: begin
          auto_inc_q <= wr_data_i[0];             // Enable bit
        end
        default: begin
          // Data window writes are dropped
        end
      endcase
    end else if (inc_i && auto_inc_q) begin
      addr_q <= addr_q + 1'b1;                    // Wraps at 22'h3FFFFF
    end
  end

  // Outputs straight from the registers
  assign flash_addr_o = addr_q;                   // To pads and readback
  assign auto_inc_o   = auto_inc_q;               // To readback mux

endmodule

`default_nettype wire

// File: logic/flash_pkg.sv
// Shared definitions for the Wishbone NOR flash read controller
// Widths, register map, access timing and sequencer states
`default_nettype none

package flash_pkg;

  // ------------------------------
  // Widths
  // ------------------------------
  localparam int DATA_W = 16;                 // Bus and flash word
  localparam int ADDR_W = 22;                 // Flash word address
  localparam int AHI_W  = ADDR_W - DATA_W;    // Address bits held in REG_AHI
  localparam int SEL_W  = 2;                  // Register offset bits
  localparam int WAIT_W = 4;                  // Access wait counter bits

  typedef logic [DATA_W-1:0] wb_data_t;       // Bus and flash data word
  typedef logic [ADDR_W-1:0] flash_addr_t;    // Flash word address
  typedef logic [SEL_W-1:0]  reg_sel_t;       // Offset on wb_adr_i
  typedef logic [WAIT_W-1:0] wait_cnt_t;      // Wait counter value

  // ------------------------------
  // Register map
  // ------------------------------
  localparam reg_sel_t REG_DATA = 2'd0;       // Flash read window
  localparam reg_sel_t REG_ALO  = 2'd1;       // Address bits 15..0
  localparam reg_sel_t REG_AHI  = 2'd2;       // Address bits 21..16
  localparam reg_sel_t REG_CTRL = 2'd3;       // Bit 0 auto-increment

  // Flash access time in clocks
  localparam wait_cnt_t ACCESS_WAIT = 4'd4;

  // Bus cycle sequencer states
  typedef enum logic [1:0] {
    IDLE,                                     // Waiting for a request
    READ_WAIT,                                // Strobes low, counting access time
    ACK                                       // Single acknowledge cycle
  } flash_state_t;

endpackage

`default_nettype wire
